// ==== design/rl_force_pkg.sv ====
`default_nettype none

package rl_force_pkg;

	localparam int COORD_W    = 12;   // Unsigned position inside the home region
	localparam int DISP_W     = 13;   // Signed nb minus ref
	localparam int R2_W       = 26;
	localparam int COEF_W     = 16;
	localparam int FORCE_W    = 24;
	localparam int PID_W      = 7;
	localparam int CID_W      = 3;
	localparam int SEG_W      = 4;
	localparam int COEF_SHIFT = 8;    // Coefficients carry 8 fraction bits

	// Force coefficient per distance segment, repulsive near and mildly attractive far
	localparam logic signed [COEF_W-1:0] COEF_TABLE [2**SEG_W] = '{
		16'sd4096, 16'sd2048, 16'sd1024, 16'sd640,
		16'sd384,  16'sd256,  16'sd160,  16'sd96,
		16'sd48,   16'sd16,   -16'sd16,  -16'sd32,
		-16'sd40,  -16'sd32,  -16'sd16,  -16'sd8
	};

	typedef struct packed {
		logic [CID_W-1:0] cell_z;
		logic [CID_W-1:0] cell_y;
		logic [CID_W-1:0] cell_x;
		logic [PID_W-1:0] index;
	} particle_id_t;

	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] z;
	} pos_t;

	typedef struct packed {
		pos_t         ref_pos;
		pos_t         nb_pos;
		particle_id_t ref_id;
		particle_id_t nb_id;
	} pair_in_t;

	typedef struct packed {
		logic signed [DISP_W-1:0] dx;
		logic signed [DISP_W-1:0] dy;
		logic signed [DISP_W-1:0] dz;
		logic [R2_W-1:0]          r2;
		particle_id_t             ref_id;
		particle_id_t             nb_id;
	} pair_t;

	typedef struct packed {
		logic signed [FORCE_W-1:0] fx;
		logic signed [FORCE_W-1:0] fy;
		logic signed [FORCE_W-1:0] fz;
		particle_id_t              ref_id;
		particle_id_t              nb_id;
	} force_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_GRANT
	} arb_state_e;

endpackage

`default_nettype wire

// ==== design/pair_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module pair_filter import rl_force_pkg::*;
#(
	parameter int              LANE_DEPTH = 4,
	parameter logic [R2_W-1:0] CUTOFF2    = 4096
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     pair_valid,
	input  pair_in_t pair,
	input  logic     pop,
	output logic     fifo_valid,
	output pair_t    fifo_head,
	output logic     pair_credit,
	output logic     empty
);

	localparam int PTR_W = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
	localparam int CNT_W = $clog2(LANE_DEPTH + 1);
	localparam int RET_W = $clog2(LANE_DEPTH + 2);

	logic                     s1_valid;
	logic signed [DISP_W-1:0] s1_dx;
	logic signed [DISP_W-1:0] s1_dy;
	logic signed [DISP_W-1:0] s1_dz;
	particle_id_t             s1_ref_id;
	particle_id_t             s1_nb_id;

	logic [R2_W-1:0] sq_x;
	logic [R2_W-1:0] sq_y;
	logic [R2_W-1:0] sq_z;
	logic [R2_W-1:0] r2;
	logic            keep;
	logic            drop;
	logic            fifo_rd;
	pair_t           wr_pair;

	pair_t            mem [LANE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [RET_W-1:0] ret_pend;   // Credits owed upstream but not yet pulsed
	logic [RET_W-1:0] ret_total;

	// Stage 1: signed displacements, nb minus ref
	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= pair_valid;
	end

	always_ff @(posedge clk)
	begin
		s1_dx     <= $signed({1'b0, pair.nb_pos.x}) - $signed({1'b0, pair.ref_pos.x});
		s1_dy     <= $signed({1'b0, pair.nb_pos.y}) - $signed({1'b0, pair.ref_pos.y});
		s1_dz     <= $signed({1'b0, pair.nb_pos.z}) - $signed({1'b0, pair.ref_pos.z});
		s1_ref_id <= pair.ref_id;
		s1_nb_id  <= pair.nb_id;
	end

	// Stage 2: squares, sum and cutoff test, result goes straight into the FIFO
	assign sq_x = s1_dx * s1_dx;
	assign sq_y = s1_dy * s1_dy;
	assign sq_z = s1_dz * s1_dz;
	assign r2   = sq_x + sq_y + sq_z;

	assign keep    = s1_valid && (r2 <= CUTOFF2) && (r2 != '0);  // Self pair is dropped
	assign drop    = s1_valid && !keep;
	assign fifo_rd = pop && fifo_valid;

	always_comb
	begin
		wr_pair.dx     = s1_dx;
		wr_pair.dy     = s1_dy;
		wr_pair.dz     = s1_dz;
		wr_pair.r2     = r2;
		wr_pair.ref_id = s1_ref_id;
		wr_pair.nb_id  = s1_nb_id;
	end

	always_ff @(posedge clk)
	begin
		if (keep)
			mem[wr_ptr] <= wr_pair;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (keep)
				wr_ptr <= (wr_ptr == PTR_W'(LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (fifo_rd)
				rd_ptr <= (rd_ptr == PTR_W'(LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(keep) - CNT_W'(fifo_rd);
		end
	end

	assign fifo_valid = (count != '0);
	assign fifo_head  = mem[rd_ptr];
	assign empty      = (count == '0) && !s1_valid;

	// A drop and a pop in one cycle owe two credits, the second goes out a cycle later
	assign ret_total = ret_pend + RET_W'(drop) + RET_W'(fifo_rd);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ret_pend    <= '0;
			pair_credit <= 1'b0;
		end
		else
		begin
			pair_credit <= (ret_total != '0);
			ret_pend    <= ret_total - RET_W'(ret_total != '0);
		end
	end

	// Upstream sent without a credit if a write finds the FIFO full
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		keep |-> (count < LANE_DEPTH));

endmodule

`default_nettype wire

// ==== design/filter_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module filter_arbiter import rl_force_pkg::*;
#(
	parameter int NUM_LANES = 2,
	parameter int OUT_DEPTH = 4
)
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic [NUM_LANES-1:0]       fifo_valid,
	input  pair_t [NUM_LANES-1:0]      fifo_head,
	input  logic                       slot_credit,
	output logic [NUM_LANES-1:0]       pop,
	output logic                       issue_valid,
	output pair_t                      issue_pair
);

	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int CR_W   = $clog2(OUT_DEPTH + 1);

	arb_state_e        state;
	logic [LANE_W-1:0] last;         // Search starts one past the previous winner
	logic [LANE_W-1:0] win;
	logic              grant;
	logic [CR_W-1:0]   credit_cnt;   // Free slots in the output buffer

	always_comb
	begin : rr_search
		int idx;
		grant = 1'b0;
		win   = '0;
		pop   = '0;
		for (int i = 1; i <= NUM_LANES; i++)
		begin
			idx = (int'(last) + i) % NUM_LANES;
			if (!grant && fifo_valid[idx] && (credit_cnt != '0))
			begin
				grant = 1'b1;
				win   = LANE_W'(idx);
			end
		end
		if (grant)
			pop[win] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state      <= ARB_IDLE;
			last       <= LANE_W'(NUM_LANES - 1);   // Lane 0 wins first
			credit_cnt <= CR_W'(OUT_DEPTH);
		end
		else
		begin
			state      <= grant ? ARB_GRANT : ARB_IDLE;
			credit_cnt <= credit_cnt - CR_W'(grant) + CR_W'(slot_credit);
			if (grant)
				last <= win;
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant)
			issue_pair <= fifo_head[win];
	end

	assign issue_valid = (state == ARB_GRANT);

	// The buffer returns no more slots than were spent
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= OUT_DEPTH);

endmodule

`default_nettype wire

// ==== design/force_pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module force_pipeline import rl_force_pkg::*;
#(
	parameter logic [R2_W-1:0] CUTOFF2 = 4096
)
(
	input  logic   clk,
	input  logic   rst,
	input  logic   issue_valid,
	input  pair_t  issue_pair,
	output logic   force_valid_int,
	output force_t force_int,
	output logic   idle
);

	// Segments split the range up to the cutoff into 2**SEG_W equal parts
	localparam int SEG_LSB = ($clog2(CUTOFF2) > SEG_W) ? $clog2(CUTOFF2) - SEG_W : 0;
	localparam int PROD_W  = COEF_W + DISP_W;
	localparam logic signed [PROD_W-1:0] F_MAX = PROD_W'(2**(FORCE_W - 1) - 1);
	localparam logic signed [PROD_W-1:0] F_MIN = -F_MAX - 1;

	logic [R2_W-1:0]          seg_full;
	logic [SEG_W-1:0]         seg;
	logic                     s1_valid;
	logic                     s2_valid;
	logic signed [COEF_W-1:0] s1_coef;
	logic signed [DISP_W-1:0] s1_dx;
	logic signed [DISP_W-1:0] s1_dy;
	logic signed [DISP_W-1:0] s1_dz;
	particle_id_t             s1_ref_id;
	particle_id_t             s1_nb_id;
	logic signed [PROD_W-1:0] s2_px;
	logic signed [PROD_W-1:0] s2_py;
	logic signed [PROD_W-1:0] s2_pz;
	particle_id_t             s2_ref_id;
	particle_id_t             s2_nb_id;

	function automatic logic signed [FORCE_W-1:0] scale_sat(input logic signed [PROD_W-1:0] prod);
		logic signed [PROD_W-1:0] shifted;
		shifted = prod >>> COEF_SHIFT;
		if (shifted > F_MAX)
			return FORCE_W'(F_MAX);
		else if (shifted < F_MIN)
			return FORCE_W'(F_MIN);
		return FORCE_W'(shifted);
	endfunction

	assign seg_full = issue_pair.r2 >> SEG_LSB;
	assign seg      = (seg_full > R2_W'(2**SEG_W - 1)) ? '1 : seg_full[SEG_W-1:0];  // r2 at the cutoff

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid        <= 1'b0;
			s2_valid        <= 1'b0;
			force_valid_int <= 1'b0;
		end
		else
		begin
			s1_valid        <= issue_valid;
			s2_valid        <= s1_valid;
			force_valid_int <= s2_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		// Stage 1, table lookup
		s1_coef   <= COEF_TABLE[seg];
		s1_dx     <= issue_pair.dx;
		s1_dy     <= issue_pair.dy;
		s1_dz     <= issue_pair.dz;
		s1_ref_id <= issue_pair.ref_id;
		s1_nb_id  <= issue_pair.nb_id;
		// Stage 2, scale displacement
		s2_px     <= s1_coef * s1_dx;
		s2_py     <= s1_coef * s1_dy;
		s2_pz     <= s1_coef * s1_dz;
		s2_ref_id <= s1_ref_id;
		s2_nb_id  <= s1_nb_id;
		// Stage 3, drop fraction bits and clamp
		force_int.fx     <= scale_sat(s2_px);
		force_int.fy     <= scale_sat(s2_py);
		force_int.fz     <= scale_sat(s2_pz);
		force_int.ref_id <= s2_ref_id;
		force_int.nb_id  <= s2_nb_id;
	end

	assign idle = !(issue_valid || s1_valid || s2_valid || force_valid_int);

endmodule

`default_nettype wire

// ==== design/force_out_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module force_out_buffer import rl_force_pkg::*;
#(
	parameter int OUT_DEPTH = 4
)
(
	input  logic   clk,
	input  logic   rst,
	input  logic   force_valid_int,
	input  force_t force_int,
	input  logic   force_credit,
	output logic   force_valid,
	output force_t force_data,
	output logic   slot_credit,
	output logic   empty
);

	localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
	localparam int CNT_W = $clog2(OUT_DEPTH + 1);
	localparam int CR_W  = 8;

	force_t           mem [OUT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CR_W-1:0]  down_cnt;   // Credits granted by the consumer
	logic             send;

	assign send  = (count != '0) && (down_cnt != '0);
	assign empty = (count == '0);

	always_ff @(posedge clk)
	begin
		if (force_valid_int)
			mem[wr_ptr] <= force_int;
		if (send)
			force_data <= mem[rd_ptr];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			down_cnt    <= '0;
			force_valid <= 1'b0;
			slot_credit <= 1'b0;
		end
		else
		begin
			if (force_valid_int)
				wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (send)
				rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count       <= count + CNT_W'(force_valid_int) - CNT_W'(send);
			down_cnt    <= down_cnt + CR_W'(force_credit) - CR_W'(send);
			force_valid <= send;
			slot_credit <= send;   // Slot goes back to the arbiter with the send
		end
	end

	// Arbiter credits must cover everything still inside the pipeline
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		force_valid_int |-> (count < OUT_DEPTH));

endmodule

`default_nettype wire

// ==== design/rl_force_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module rl_force_unit import rl_force_pkg::*;
#(
	parameter int              NUM_LANES  = 2,
	parameter int              LANE_DEPTH = 4,
	parameter int              OUT_DEPTH  = 4,
	parameter logic [R2_W-1:0] CUTOFF2    = 4096
)
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic [NUM_LANES-1:0]     pair_valid,
	input  pair_in_t [NUM_LANES-1:0] pair,
	output logic [NUM_LANES-1:0]     pair_credit,
	input  logic                     force_credit,
	output logic                     force_valid,
	output force_t                   force_data,
	output logic                     all_empty
);

	logic [NUM_LANES-1:0]  lane_valid;
	pair_t [NUM_LANES-1:0] lane_head;
	logic [NUM_LANES-1:0]  lane_pop;
	logic [NUM_LANES-1:0]  lane_empty;
	logic                  issue_valid;
	pair_t                 issue_pair;
	logic                  force_valid_int;
	force_t                force_int;
	logic                  slot_credit;
	logic                  pipe_idle;
	logic                  out_empty;

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		pair_filter #(
			.LANE_DEPTH(LANE_DEPTH),
			.CUTOFF2(CUTOFF2)
		) i_pair_filter (
			.clk(clk),
			.rst(rst),
			.pair_valid(pair_valid[g]),
			.pair(pair[g]),
			.pop(lane_pop[g]),
			.fifo_valid(lane_valid[g]),
			.fifo_head(lane_head[g]),
			.pair_credit(pair_credit[g]),
			.empty(lane_empty[g])
		);
	end

	filter_arbiter #(
		.NUM_LANES(NUM_LANES),
		.OUT_DEPTH(OUT_DEPTH)
	) i_filter_arbiter (
		.clk(clk),
		.rst(rst),
		.fifo_valid(lane_valid),
		.fifo_head(lane_head),
		.slot_credit(slot_credit),
		.pop(lane_pop),
		.issue_valid(issue_valid),
		.issue_pair(issue_pair)
	);

	force_pipeline #(
		.CUTOFF2(CUTOFF2)
	) i_force_pipeline (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue_pair(issue_pair),
		.force_valid_int(force_valid_int),
		.force_int(force_int),
		.idle(pipe_idle)
	);

	force_out_buffer #(
		.OUT_DEPTH(OUT_DEPTH)
	) i_force_out_buffer (
		.clk(clk),
		.rst(rst),
		.force_valid_int(force_valid_int),
		.force_int(force_int),
		.force_credit(force_credit),
		.force_valid(force_valid),
		.force_data(force_data),
		.slot_credit(slot_credit),
		.empty(out_empty)
	);

	assign all_empty = (&lane_empty) && pipe_idle && out_empty;

endmodule

`default_nettype wire

// ==== testbench/rl_force_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rl_force_tb
	import rl_force_pkg::*;
();

	localparam int NUM_LANES      = 2;
	localparam int LANE_DEPTH     = 4;
	localparam int OUT_DEPTH      = 4;
	localparam int RNG_SEED       = 578;
	localparam int CONSUMER_SLOTS = 4;   // Credits the consumer may have outstanding
	localparam int GRANT_NONE     = 0;
	localparam int GRANT_READY    = 1;
	localparam int GRANT_RANDOM   = 2;

	logic                     clk;
	logic                     rst;
	logic [NUM_LANES-1:0]     pair_valid;
	pair_in_t [NUM_LANES-1:0] pair_in;
	logic [NUM_LANES-1:0]     pair_credit;
	logic                     force_credit;
	logic                     force_valid;
	force_t                   force_data;
	logic                     all_empty;

	// Whole stimulus file that the tests index into
	pair_in_t pairs_all[$];
	int       pair_lane_all[$];
	force_t   exp_all[$];
	int       exp_lane_all[$];
	int       t_mode[$];
	int       t_grants[$];
	int       t_pair_lo[$];
	int       t_pair_hi[$];
	int       t_exp_lo[$];
	int       t_exp_hi[$];
	int       t_discards[$];

	pair_in_t lane_send[NUM_LANES][$];
	force_t   lane_exp[NUM_LANES][$];   // Expected forces in lane order
	int       lane_sent[NUM_LANES] = '{default: 0};
	int       lane_ret[NUM_LANES] = '{default: 0};
	int       sent;
	int       recv;
	int       returned;
	int       granted;
	int       exp_total;
	int       pairs_total;
	int       errors;
	int       tests_passed;
	bit       hold;
	bit       loaded;

	rl_force_unit #(
		.NUM_LANES(NUM_LANES),
		.LANE_DEPTH(LANE_DEPTH),
		.OUT_DEPTH(OUT_DEPTH),
		.CUTOFF2(4096)
	) i_rl_force_unit (
		.clk(clk),
		.rst(rst),
		.pair_valid(pair_valid),
		.pair(pair_in),
		.pair_credit(pair_credit),
		.force_credit(force_credit),
		.force_valid(force_valid),
		.force_data(force_data),
		.all_empty(all_empty)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("FAILED at %0t: %s got %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_force(input force_t exp);
		check_value("force_data.fx", int'($signed(force_data.fx)), int'($signed(exp.fx)));
		check_value("force_data.fy", int'($signed(force_data.fy)), int'($signed(exp.fy)));
		check_value("force_data.fz", int'($signed(force_data.fz)), int'($signed(exp.fz)));
		check_value("force_data.ref_id", int'(force_data.ref_id), int'(exp.ref_id));
		check_value("force_data.nb_id", int'(force_data.nb_id), int'(exp.nb_id));
	endtask

	task automatic load_stimulus();
		int       fd;
		string    line;
		string    body;
		byte      tag;
		int       n;
		int       want;
		int       lane;
		int       rx;
		int       ry;
		int       rz;
		int       nx;
		int       ny;
		int       nz;
		int       rid;
		int       nid;
		pair_in_t p;
		force_t   f;
		fd = $fopen("testbench/rl_force_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open testbench/rl_force_stimulus.txt");
			errors++;
		end
		else
		begin
			while ($fgets(line, fd) > 0)
			begin
				tag  = line.getc(0);
				body = line.substr(1, line.len() - 1);
				n    = 0;
				want = 0;
				case (tag)
					"T":
					begin
						n    = $sscanf(body, "%d %d", rx, ry);
						want = 2;
						t_mode.push_back(rx);
						t_grants.push_back(ry);
						t_pair_lo.push_back(pairs_all.size());
						t_exp_lo.push_back(exp_all.size());
					end
					"P":
					begin
						n = $sscanf(body, "%d %d %d %d %d %d %d %h %h",
							lane, rx, ry, rz, nx, ny, nz, rid, nid);
						want = 9;
						p.ref_pos.x = COORD_W'(rx);
						p.ref_pos.y = COORD_W'(ry);
						p.ref_pos.z = COORD_W'(rz);
						p.nb_pos.x  = COORD_W'(nx);
						p.nb_pos.y  = COORD_W'(ny);
						p.nb_pos.z  = COORD_W'(nz);
						p.ref_id    = 16'(rid);
						p.nb_id     = 16'(nid);
						pairs_all.push_back(p);
						pair_lane_all.push_back(lane);
					end
					"F":
					begin
						n    = $sscanf(body, "%d %d %d %d %h %h", lane, rx, ry, rz, rid, nid);
						want = 6;
						f.fx     = FORCE_W'(rx);
						f.fy     = FORCE_W'(ry);
						f.fz     = FORCE_W'(rz);
						f.ref_id = 16'(rid);
						f.nb_id  = 16'(nid);
						exp_all.push_back(f);
						exp_lane_all.push_back(lane);
					end
					"D":
					begin
						n    = $sscanf(body, "%d", rx);
						want = 1;
						t_discards.push_back(rx);
						t_pair_hi.push_back(pairs_all.size());
						t_exp_hi.push_back(exp_all.size());
					end
					default: ;   // Comment or blank line
				endcase
				assert (n == want)
				else
				begin
					$display("malformed stimulus line: %s", line);
					errors++;
				end
			end
			$fclose(fd);
		end
	endtask

	// One clock of stimulus driven just after the edge
	task automatic drive_cycle(input int grant_mode);
		int avail;
		bit give;
		@(posedge clk);
		#1;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			avail         = LANE_DEPTH + lane_ret[l] - lane_sent[l];
			pair_valid[l] = 1'b0;
			if (lane_send[l].size() > 0 && avail > 0)
			begin
				pair_in[l]    = lane_send[l].pop_front();
				pair_valid[l] = 1'b1;
				lane_sent[l]++;
				sent++;
			end
		end
		give = (granted < exp_total) && (granted - recv < CONSUMER_SLOTS);
		if (grant_mode == GRANT_NONE)
			give = 1'b0;
		else if (grant_mode == GRANT_RANDOM)
			give = give && ($urandom % 2 == 0);
		force_credit = give;
		if (give)
			granted++;
	endtask

	// Credit returns and forces are sampled on the edge
	always @(posedge clk)
	begin : monitor
		int hit;
		hit = -1;
		if (!rst)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (pair_credit[l])
				begin
					lane_ret[l]++;
					returned++;
				end
				assert (lane_ret[l] <= lane_sent[l])
				else
				begin
					$display("lane %0d returned more credits than pairs sent at %0t",
						l, $time);
					errors++;
				end
			end
			if (force_valid)
			begin
				recv++;
				assert (!hold)
				else
				begin
					$display("force_valid rose at %0t while consumer credits were withheld", $time);
					errors++;
				end
				for (int l = 0; l < NUM_LANES; l++)
				begin
					if (hit < 0 && lane_exp[l].size() > 0 &&
						lane_exp[l][0].ref_id == force_data.ref_id &&
						lane_exp[l][0].nb_id == force_data.nb_id)
						hit = l;
				end
				assert (hit >= 0)
				else
				begin
					$display("force at %0t with ref_id %h nb_id %h is not next in any lane",
						$time, force_data.ref_id, force_data.nb_id);
					errors++;
				end
				if (hit >= 0)
					compare_force(lane_exp[hit].pop_front());
			end
		end
	end

	task automatic run_test(input int t);
		int err_base;
		int drain_mode;
		err_base    = errors;
		sent        = 0;
		recv        = 0;
		returned    = 0;
		granted     = 0;
		exp_total   = t_exp_hi[t] - t_exp_lo[t];
		pairs_total = t_pair_hi[t] - t_pair_lo[t];
		for (int i = t_pair_lo[t]; i < t_pair_hi[t]; i++)
			lane_send[pair_lane_all[i]].push_back(pairs_all[i]);
		for (int i = t_exp_lo[t]; i < t_exp_hi[t]; i++)
			lane_exp[exp_lane_all[i]].push_back(exp_all[i]);
		drain_mode = (t_mode[t] == 2) ? GRANT_RANDOM : GRANT_READY;
		if (t_mode[t] == 1)
		begin
			hold = 1'b1;   // Buffer and lanes fill up and nothing may leave
			while (sent < pairs_total)
				drive_cycle(GRANT_NONE);
			repeat (40) drive_cycle(GRANT_NONE);
			check_value("force_valid count while withheld", recv, 0);
			check_value("all_empty", int'(all_empty), 0);
			hold = 1'b0;
			repeat (t_grants[t]) drive_cycle(GRANT_READY);
			repeat (20) drive_cycle(GRANT_NONE);
			check_value("force_valid count after grant", recv, t_grants[t]);
		end
		while (!(sent == pairs_total && recv >= exp_total && all_empty))
			drive_cycle(drain_mode);
		repeat (6) drive_cycle(GRANT_NONE);   // Late credit pulses
		check_value("force_valid count", recv, exp_total);
		check_value("discarded pairs", sent - recv, t_discards[t]);
		check_value("pair_credit returns", returned, sent);
		if (errors == err_base)
		begin
			tests_passed++;
			$display("test %0d: ok, %0d pairs sent, %0d forces", t + 1, sent, recv);
		end
		else
			$display("test %0d: %0d errors", t + 1, errors - err_base);
	endtask

	initial
	begin
		rst          = 1'b1;
		pair_valid   = '0;
		pair_in      = '0;
		force_credit = 1'b0;
		errors       = 0;
		tests_passed = 0;
		hold         = 1'b0;
		loaded       = 1'b0;
		void'($urandom(RNG_SEED));
		load_stimulus();
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		assert (all_empty)
		else
		begin
			$display("all_empty is low right after reset");
			errors++;
		end
		for (int t = 0; t < t_mode.size(); t++)
			run_test(t);
		$display("passed %0d of %0d tests, %0d errors", tests_passed, t_mode.size(), errors);
		if (errors == 0 && t_mode.size() > 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin : watchdog
		int limit;
		wait (loaded);
		limit = 200 * pairs_all.size() + 1000;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, a test never drained", limit);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rl_force.f ====
design/rl_force_pkg.sv
design/pair_filter.sv
design/filter_arbiter.sv
design/force_pipeline.sv
design/force_out_buffer.sv
design/rl_force_unit.sv
testbench/rl_force_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the rl_force testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/rl_force_sim

verilator --binary --timing --assert -Wno-fatal \
	-f rl_force.f --top-module rl_force_tb \
	-Mdir obj_dir -o rl_force_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	echo "RESULT: FAIL"
	exit 1
fi
echo "RESULT: PASS"
exit 0

// ==== testbench/rl_force_stimulus.txt ====
# T mode grants (0 free consumer, 1 credits withheld, 2 random) | D discards closes a test
# P lane ref_x ref_y ref_z nb_x nb_y nb_z ref_id nb_id | F lane fx fy fz ref_id nb_id
T 0 0
P 0 100 100 100 110 105 97 0015 0023
F 0 160 80 -48 0015 0023
D 0
T 0 0
P 0 100 100 100 200 100 100 0101 0102
P 0 50 60 70 50 60 70 0101 0103
P 1 0 0 0 64 1 0 0201 0202
P 1 1000 1000 1000 1000 1064 1000 0201 0203
F 1 0 -2 0 0201 0203
D 3
T 0 0
P 0 500 500 500 520 510 505 0301 0311
P 0 300 300 300 280 330 300 0301 0312
P 0 10 10 10 50 10 10 0301 0313
P 1 2000 2000 2000 1990 2000 2003 0302 0321
P 1 700 700 700 700 745 730 0302 0322
P 1 4000 4000 4000 3950 4000 4020 0302 0323
F 0 80 40 20 0301 0311
F 0 -20 30 0 0301 0312
F 0 25 0 0 0301 0313
F 1 -160 0 48 0302 0321
F 1 0 -6 -4 0302 0322
F 1 6 0 -3 0302 0323
D 0
T 1 2
P 0 100 200 300 101 200 300 0401 0411
P 0 100 200 300 100 202 300 0401 0412
P 0 100 200 300 100 200 297 0401 0413
P 0 100 200 300 104 203 300 0401 0414
P 1 800 900 1000 795 900 1000 0402 0421
P 1 800 900 1000 800 908 1006 0402 0422
F 0 16 0 0 0401 0411
F 0 0 32 0 0401 0412
F 0 0 0 -48 0401 0413
F 0 64 48 0 0401 0414
F 1 -80 0 0 0402 0421
F 1 0 128 96 0402 0422
D 0
T 2 0
P 0 1000 1000 1000 1060 1000 1000 0501 0511
P 0 1000 1000 1000 1000 1030 1030 0501 0512
P 0 1000 1000 1000 1000 1000 1100 0501 0513
P 0 1000 1000 1000 985 1000 990 0501 0514
P 0 1000 1000 1000 1020 1020 1020 0501 0515
P 1 3000 3000 3000 3040 3030 3000 0502 0521
P 1 3000 3000 3000 3000 3000 3000 0502 0522
P 1 3000 3000 3000 2950 2980 3000 0502 0523
P 1 3000 3000 3000 3020 2990 3050 0502 0524
F 0 -4 0 0 0501 0511
F 0 0 11 11 0501 0512
F 0 -120 0 -80 0501 0514
F 0 30 30 30 0501 0515
F 1 2 1 0 0502 0521
F 1 6 2 0 0502 0523
F 1 -3 1 -7 0502 0524
D 2
